/* bench/displayListTranslate_checker.sv */
/* Port-level protocol assertions, bound to every displayListTranslate instance.
   Nothing is checked while rst is high */
module displayListTranslate_checker (
  input logic              Fphi0,
  input logic              rst,
  input anticPkg::anCode_t AN,
  input logic              idle,
  input logic              loadIR,
  input logic              loadDLISTL,
  input logic              loadDLISTH,
  input logic              loadMSRL,
  input logic              loadMSRH
);

  // Each byte request is a single pulse
  singleLoadIR: assert property (@(posedge Fphi0) disable iff (rst) loadIR |=> !loadIR)
    else $error("loadIR high for two cycles in a row");

  // No pixel codes between instructions
  quietWhenIdle: assert property (@(posedge Fphi0) disable iff (rst)
                                  idle |-> AN == anticPkg::NONE)
    else $error("AN not NONE while idle");

  jumpBytesApart: assert property (@(posedge Fphi0) disable iff (rst)
                                   !(loadDLISTL && loadDLISTH))
    else $error("loadDLISTL and loadDLISTH high together");

  lmsBytesApart: assert property (@(posedge Fphi0) disable iff (rst) !(loadMSRL && loadMSRH))
    else $error("loadMSRL and loadMSRH high together");

endmodule

bind displayListTranslate displayListTranslate_checker checks (
  .Fphi0(Fphi0), .rst(rst), .AN(AN), .idle(idle), .loadIR(loadIR),
  .loadDLISTL(loadDLISTL), .loadDLISTH(loadDLISTH), .loadMSRL(loadMSRL), .loadMSRH(loadMSRH)
);

/* bench/tb_displayListTranslate.sv */
/* Testbench for displayListTranslate with a memory model that answers every request.
   The display list is fixed; operands, data bytes and bitmaps come from a fixed seed */
`include "antic_settings.svh"

module tb_displayListTranslate;

  localparam int Timeout = 100000;

  logic Fphi0 = 1'b0;
  logic rst;
  logic [7:0] IR;
  logic IRrdy;
  logic [7:0] DMACTL;
  logic MSRdataRdy;
  logic [7:0] MSRdata;
  logic [63:0] charData;
  logic charLoaded;
  anticPkg::anCode_t AN;
  logic idle, loadIR, loadPtr, loadDLISTL, loadDLISTH, loadDLIST, writeDLIST, DLISTend;
  logic loadMSRL, loadMSRH, loadMSRdata, incrMSR, loadChar;

  logic [7:0] dlist[$];
  logic [7:0] dmaList[$];
  bit isInstr[$];
  anticPkg::anCode_t expQ[$];
  int seed = 32'h4d36;
  int ptr, irDelay, msrDelay, charDelay;
  bit listDone;
  anticPkg::mode_t curMode;
  logic curJvb;
  anticPkg::anCode_t prevCode;
  logic wasIdle;
  int errorCount, checkCount, codesSeen, jumpStep;
  int expLMS, expData, expChar, expJump, expJvb, expCodes;
  int nLoadIR, nMSRL, nMSRH, nData, nIncr, nChar, nDLISTL, nDLISTH, nDLIST, nWrite, nEnd;

  displayListTranslate DUT (.*);

  always #10 Fphi0 = ~Fphi0;

  // Expected code k of one instruction line, a data byte or a character bitmap
  function automatic anticPkg::anCode_t refCode(input anticPkg::mode_t mode,
                                                input logic [63:0] data, input int k);
    logic [1:0] pair;
    refCode = anticPkg::BG;
    if (mode == anticPkg::CHAR2) begin
      refCode = data[k] ? anticPkg::PF1 : anticPkg::PF2;
    end else if (mode == anticPkg::MAP14) begin
      pair = {data[2*k], data[2*k+1]};
      case (pair)
        2'd0: refCode = anticPkg::BG;
        2'd1: refCode = anticPkg::PF0;
        2'd2: refCode = anticPkg::PF1;
        default: refCode = anticPkg::PF2;
      endcase
    end
  endfunction

  function automatic int bytesPerLine(input logic [7:0] dma);
    case (dma[1:0])
      2'd1: return `NARROW_BYTES;
      2'd2: return `STANDARD_BYTES;
      2'd3: return `WIDE_BYTES;
      default: return 0;
    endcase
  endfunction

  task automatic checkValue(input string name, input int actual, input int expected);
    checkCount++;
    if (actual != expected) begin
      errorCount++;
      $display("FAILED at time %0t: %s = %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  // Appends one instruction and its operand bytes, and adds up what it should produce
  task automatic addInstr(input logic [7:0] instr, input logic [7:0] dma);
    int bytes;
    int opCount;
    bytes = bytesPerLine(dma);
    opCount = 0;
    case (instr[3:0])
      4'd0: expCodes += (instr[6:4] + 1) * `SCAN_LINES_PER_BLANK * `PIXELS_PER_LINE;
      4'd1: begin
        opCount = 2;
        expJump++;
        expJvb += instr[6];
      end
      4'd2, 4'd14: begin
        if (instr[6]) begin
          opCount = 2;
          expLMS++;
        end
        expData += bytes;
        if (instr[3:0] == 4'd2) begin
          expChar += bytes;
          expCodes += bytes * `CHAR_BITS;
        end else begin
          expCodes += bytes * 4;
        end
      end
      default: ;
    endcase
    dlist.push_back(instr);
    dmaList.push_back(dma);
    isInstr.push_back(1'b1);
    repeat (opCount) begin
      dlist.push_back(8'($random(seed)));
      dmaList.push_back(dma);
      isInstr.push_back(1'b0);
    end
  endtask

  // The first display-list byte comes unasked a few cycles after reset
  always @(negedge Fphi0) begin
    IRrdy <= 1'b0;
    if (rst) begin
      irDelay = 3;
    end else begin
      if (irDelay != 0) begin
        irDelay = irDelay - 1;
        if (irDelay == 0) begin
          IR <= dlist[ptr];
          IRrdy <= 1'b1;
          if (isInstr[ptr]) begin
            curMode = anticPkg::mode_t'(dlist[ptr][3:0]);
            curJvb = dlist[ptr][6];
            DMACTL <= dmaList[ptr];
            if (curMode == anticPkg::BLANK)
              for (int k = 0; k < (dlist[ptr][6:4] + 1) * `SCAN_LINES_PER_BLANK
                                  * `PIXELS_PER_LINE; k++)
                expQ.push_back(refCode(anticPkg::BLANK, 64'd0, k));
          end
          ptr++;
        end
      end
      if (loadIR) begin
        if (ptr == dlist.size())
          listDone = 1'b1;
        else
          irDelay = 2;
      end
    end
  end

  // Screen memory and character generator
  always @(negedge Fphi0) begin
    logic [7:0] data;
    logic [63:0] bitmap;
    MSRdataRdy <= 1'b0;
    charLoaded <= 1'b0;
    if (msrDelay != 0) begin
      msrDelay = msrDelay - 1;
      if (msrDelay == 0) begin
        data = 8'($random(seed));
        MSRdata <= data;
        MSRdataRdy <= 1'b1;
        if (curMode == anticPkg::MAP14)
          for (int k = 0; k < 4; k++)
            expQ.push_back(refCode(anticPkg::MAP14, {56'd0, data}, k));
      end
    end
    if (charDelay != 0) begin
      charDelay = charDelay - 1;
      if (charDelay == 0) begin
        bitmap = {$random(seed), $random(seed)};
        charData <= bitmap;
        charLoaded <= 1'b1;
        for (int k = 0; k < `CHAR_BITS; k++)
          expQ.push_back(refCode(anticPkg::CHAR2, bitmap, k));
      end
    end
    if (loadMSRdata)
      msrDelay = 3;
    if (loadChar)
      charDelay = 2;
  end

  always @(negedge Fphi0) begin
    anticPkg::anCode_t expected;
    if (!rst) begin
      if (AN != anticPkg::NONE) begin
        codesSeen++;
        if (expQ.size() == 0) begin
          errorCount++;
          $display("AN sent code %b at time %0t while no code was expected", AN, $time);
        end else begin
          expected = expQ.pop_front();
          checkValue("AN", AN, expected);
        end
      end
      // The blank run is closed by loadIR in the cycle after its last BG code
      if (curMode == anticPkg::BLANK && prevCode == anticPkg::BG && AN != anticPkg::BG)
        checkValue("loadIR", loadIR, 1);
      if (wasIdle && IRrdy)
        checkValue("idle", idle, 0);
      if (loadDLISTL) begin
        checkValue("jump step at loadDLISTL", jumpStep, 0);
        checkValue("loadPtr", loadPtr, 1);
        jumpStep = 1;
      end
      if (loadDLISTH) begin
        checkValue("jump step at loadDLISTH", jumpStep, 1);
        checkValue("writeDLIST", writeDLIST, 1);
        checkValue("loadPtr", loadPtr, 1);
        jumpStep = 2;
      end
      if (loadDLIST) begin
        checkValue("jump step at loadDLIST", jumpStep, 2);
        checkValue("DLISTend", DLISTend, curJvb);
        jumpStep = 0;
      end
      if (DLISTend)
        checkValue("loadDLIST", loadDLIST, 1);
      nLoadIR += loadIR;
      nMSRL += loadMSRL;
      nMSRH += loadMSRH;
      nData += loadMSRdata;
      nIncr += incrMSR;
      nChar += loadChar;
      nDLISTL += loadDLISTL;
      nDLISTH += loadDLISTH;
      nDLIST += loadDLIST;
      nWrite += writeDLIST;
      nEnd += DLISTend;
      prevCode = AN;
      wasIdle = idle;
    end
  end

  initial begin
    int cycles;
    rst = 1'b1;
    IR = '0;
    IRrdy = 1'b0;
    DMACTL = '0;
    MSRdataRdy = 1'b0;
    MSRdata = '0;
    charData = '0;
    charLoaded = 1'b0;
    curMode = anticPkg::JUMP;
    prevCode = anticPkg::NONE;
    wasIdle = 1'b0;
    addInstr(8'h00, 8'h00);
    addInstr(8'h20, 8'h00);
    addInstr(8'h42, 8'h02);
    addInstr(8'h0E, 8'h01);
    addInstr(8'h4E, 8'h03);
    addInstr(8'h0E, 8'h00);
    addInstr(8'h01, 8'h02);
    addInstr(8'h41, 8'h02);
    repeat (2) @(negedge Fphi0);
    rst <= 1'b0;
    @(negedge Fphi0);
    checkValue("idle", idle, 1);
    checkValue("AN", AN, anticPkg::NONE);
    checkValue("strobe outputs", {loadIR, loadPtr, loadDLISTL, loadDLISTH, loadDLIST,
               writeDLIST, DLISTend, loadMSRL, loadMSRH, loadMSRdata, incrMSR, loadChar}, 0);
    cycles = 0;
    while (!listDone && cycles < Timeout) begin
      @(posedge Fphi0);
      cycles++;
    end
    if (!listDone) begin
      errorCount++;
      $display("Display list did not finish within %0d cycles", Timeout);
    end
    checkValue("loadIR count", nLoadIR, dlist.size());
    checkValue("loadMSRL count", nMSRL, expLMS);
    checkValue("loadMSRH count", nMSRH, expLMS);
    checkValue("loadMSRdata count", nData, expData);
    checkValue("incrMSR count", nIncr, expData);
    checkValue("loadChar count", nChar, expChar);
    checkValue("loadDLISTL count", nDLISTL, expJump);
    checkValue("loadDLISTH count", nDLISTH, expJump);
    checkValue("loadDLIST count", nDLIST, expJump);
    checkValue("writeDLIST count", nWrite, expJump);
    checkValue("DLISTend count", nEnd, expJvb);
    checkValue("AN code count", codesSeen, expCodes);
    checkValue("codes never sent", expQ.size(), 0);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* include/antic_settings.svh */
/* Widths and line geometry shared by the display-list translator.
   Byte counts only cover the three playfield widths of DMACTL[1:0] */
`ifndef ANTIC_SETTINGS_SVH
`define ANTIC_SETTINGS_SVH

// Display-list and data bytes
`define IR_WIDTH 8
`define BYTE_COUNT_WIDTH 7

// TV geometry for blank mode lines
`define PIXELS_PER_LINE 320
`define SCAN_LINES_PER_BLANK 8
`define BLANK_COUNT_WIDTH 15

// One 8x8 character bitmap
`define CHAR_BITS 64

// Bytes per mode line for narrow, standard and wide playfields
`define NARROW_BYTES 32
`define STANDARD_BYTES 40
`define WIDE_BYTES 48

`endif

/* run.sh */
#!/bin/sh
# Builds the display-list translator testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_displayListTranslate -o simDisplayList
out=$(./obj_dir/simDisplayList 2>&1 || true)
echo "$out"
echo "$out" | grep -qx "Simulation passed"

/* src.f */
+incdir+include
verilog/anticPkg.sv
verilog/anticIf.sv
verilog/instrDecoder.sv
verilog/operandFetch.sv
verilog/modeLineEngine.sv
verilog/displayListTranslate.sv
bench/displayListTranslate_checker.sv
bench/tb_displayListTranslate.sv

/* verilog/anticIf.sv */
/* Buses between the instruction decoder, the operand fetcher and the line engine.
   All strobes on these buses are single-cycle pulses */
`include "antic_settings.svh"

interface operandIf;
  logic start;
  anticPkg::operandKind_t kind;
  logic byteRequest;
  logic byteReady;
  // Instruction byte that owns the operand, held by the decoder
  logic [`IR_WIDTH-1:0] operandByte;
  logic done;

  modport decoder (output start, kind, byteReady, operandByte, input byteRequest, done);
  modport fetcher (input start, kind, byteReady, output byteRequest, done);
endinterface

interface lineIf;
  logic start;
  anticPkg::mode_t mode;
  logic [`BYTE_COUNT_WIDTH-1:0] byteCount;
  logic done;

  modport decoder (output start, mode, byteCount, input done);
  modport engine (input start, mode, byteCount, output done);
endinterface

/* verilog/anticPkg.sv */
/* Types shared by the display-list translator.
   Only the pixel codes used by modes 0, 2 and 14 are named */
package anticPkg;

  // Pixel code sent to the colour chip each clock
  typedef enum logic [3:0] {
    NONE = 4'b1000,
    BG   = 4'b0000,
    PF0  = 4'b0100,
    PF1  = 4'b0101,
    PF2  = 4'b0110
  } anCode_t;

  // Low nibble of a display-list instruction
  // Other values are legal and are treated as no-ops
  typedef enum logic [3:0] {
    BLANK = 4'd0,
    JUMP  = 4'd1,
    CHAR2 = 4'd2,
    MAP14 = 4'd14
  } mode_t;

  // What the two bytes after an instruction are used for
  typedef enum logic {
    JUMP_OPERAND,
    LMS_OPERAND
  } operandKind_t;

endpackage

/* verilog/displayListTranslate.sv */
/* Display-list translator for modes 0, 1, 2 and 14; no DLI and no vblank handling.
   The environment must answer every loadIR, loadMSRdata and loadChar request */
`include "antic_settings.svh"

module displayListTranslate (
  input  logic                     Fphi0,
  input  logic                     rst,
  input  logic [`IR_WIDTH-1:0]     IR,
  input  logic                     IRrdy,
  input  logic [7:0]               DMACTL,
  input  logic                     MSRdataRdy,
  input  logic [`IR_WIDTH-1:0]     MSRdata,
  input  logic [`CHAR_BITS-1:0]    charData,
  input  logic                     charLoaded,
  output anticPkg::anCode_t        AN,
  output logic                     idle,
  output logic                     loadIR,
  output logic                     loadPtr,
  output logic                     loadDLISTL,
  output logic                     loadDLISTH,
  output logic                     loadDLIST,
  output logic                     writeDLIST,
  output logic                     DLISTend,
  output logic                     loadMSRL,
  output logic                     loadMSRH,
  output logic                     loadMSRdata,
  output logic                     incrMSR,
  output logic                     loadChar
);

  operandIf operandBus ();
  lineIf lineBus ();

  anticPkg::anCode_t blankCode;
  anticPkg::anCode_t pixelCode;
  logic jvb;

  // Bit 6 of a jump instruction selects jump-and-wait-for-vblank
  assign jvb = operandBus.operandByte[6];

  // The decoder and the engine never emit codes in the same cycle
  assign AN = (blankCode != anticPkg::NONE) ? blankCode : pixelCode;

  instrDecoder decoder (
    .Fphi0(Fphi0), .rst(rst), .IR(IR), .IRrdy(IRrdy), .DMACTL(DMACTL),
    .operand(operandBus.decoder), .line(lineBus.decoder),
    .idle(idle), .loadIR(loadIR), .blankCode(blankCode)
  );

  operandFetch fetcher (
    .Fphi0(Fphi0), .rst(rst), .operand(operandBus.fetcher), .jvb(jvb),
    .loadPtr(loadPtr), .loadDLISTL(loadDLISTL), .loadDLISTH(loadDLISTH),
    .loadDLIST(loadDLIST), .writeDLIST(writeDLIST), .DLISTend(DLISTend),
    .loadMSRL(loadMSRL), .loadMSRH(loadMSRH)
  );

  modeLineEngine engine (
    .Fphi0(Fphi0), .rst(rst), .MSRdataRdy(MSRdataRdy), .MSRdata(MSRdata),
    .charData(charData), .charLoaded(charLoaded), .line(lineBus.engine),
    .loadMSRdata(loadMSRdata), .incrMSR(incrMSR), .loadChar(loadChar),
    .pixelCode(pixelCode)
  );

endmodule

/* verilog/instrDecoder.sv */
/* Instruction capture and dispatch; runs blank lines itself.
   Modes other than 0, 1, 2 and 14 end at once with the next loadIR */
`include "antic_settings.svh"

module instrDecoder (
  input  logic                   Fphi0,
  input  logic                   rst,
  input  logic [`IR_WIDTH-1:0]   IR,
  input  logic                   IRrdy,
  input  logic [7:0]             DMACTL,
  operandIf.decoder              operand,
  lineIf.decoder                 line,
  output logic                   idle,
  output logic                   loadIR,
  output anticPkg::anCode_t      blankCode
);

  typedef enum logic [2:0] {S_IDLE, S_DISPATCH, S_BLANK, S_FETCH, S_LINE} decState_t;

  decState_t state;
  logic [`IR_WIDTH-1:0] instr;
  anticPkg::mode_t instrMode;
  logic isDisplay;
  logic [`BLANK_COUNT_WIDTH-1:0] blankCount;
  logic [`BLANK_COUNT_WIDTH-1:0] blankTotal;
  logic [`BYTE_COUNT_WIDTH-1:0] widthBytes;
  logic [`BYTE_COUNT_WIDTH-1:0] lineBytes;
  anticPkg::mode_t lineMode;
  logic loadIRq;
  logic lineStart;

  assign instrMode = anticPkg::mode_t'(instr[3:0]);
  assign isDisplay = (instrMode == anticPkg::CHAR2) || (instrMode == anticPkg::MAP14);
  assign idle = (state == S_IDLE);

  // Codes in n+1 blank mode lines, less the one sent on dispatch
  assign blankTotal = `BLANK_COUNT_WIDTH'((instr[6:4] + 1) * `SCAN_LINES_PER_BLANK
                                          * `PIXELS_PER_LINE - 1);

  always_comb begin
    case (DMACTL[1:0])
      2'd1: widthBytes = `BYTE_COUNT_WIDTH'(`NARROW_BYTES);
      2'd2: widthBytes = `BYTE_COUNT_WIDTH'(`STANDARD_BYTES);
      2'd3: widthBytes = `BYTE_COUNT_WIDTH'(`WIDE_BYTES);
      default: widthBytes = '0;
    endcase
  end

  // Jumps always fetch two bytes, display modes only with LMS in bit 6
  assign operand.start = (state == S_DISPATCH) &&
                         ((instrMode == anticPkg::JUMP) || (isDisplay && instr[6]));
  assign operand.kind = (instrMode == anticPkg::JUMP) ? anticPkg::JUMP_OPERAND
                                                      : anticPkg::LMS_OPERAND;
  assign operand.byteReady = IRrdy && !idle;
  assign operand.operandByte = instr;

  assign line.start = lineStart;
  assign line.mode = lineMode;
  assign line.byteCount = lineBytes;

  assign loadIR = loadIRq || operand.byteRequest;

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      state <= S_IDLE;
      loadIRq <= 1'b0;
      lineStart <= 1'b0;
      blankCount <= '0;
      blankCode <= anticPkg::NONE;
    end else begin
      loadIRq <= 1'b0;
      lineStart <= 1'b0;
      case (state)
        S_IDLE: begin
          if (IRrdy)
            state <= S_DISPATCH;
        end
        S_DISPATCH: begin
          case (instrMode)
            anticPkg::BLANK: begin
              blankCount <= blankTotal;
              blankCode <= anticPkg::BG;
              state <= S_BLANK;
            end
            anticPkg::JUMP: state <= S_FETCH;
            anticPkg::CHAR2, anticPkg::MAP14: begin
              if (instr[6]) begin
                state <= S_FETCH;
              end else begin
                lineStart <= 1'b1;
                state <= S_LINE;
              end
            end
            default: begin
              loadIRq <= 1'b1;
              state <= S_IDLE;
            end
          endcase
        end
        S_BLANK: begin
          if (blankCount == '0) begin
            blankCode <= anticPkg::NONE;
            loadIRq <= 1'b1;
            state <= S_IDLE;
          end else begin
            blankCount <= blankCount - 1'b1;
          end
        end
        S_FETCH: begin
          if (operand.done) begin
            // After LMS the mode line itself still has to run
            if (instrMode == anticPkg::JUMP) begin
              loadIRq <= 1'b1;
              state <= S_IDLE;
            end else begin
              lineStart <= 1'b1;
              state <= S_LINE;
            end
          end
        end
        S_LINE: begin
          if (line.done) begin
            loadIRq <= 1'b1;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge Fphi0) begin
    if (idle && IRrdy)
      instr <= IR;
    // Playfield width is sampled once per mode line
    if (state == S_DISPATCH) begin
      lineMode <= instrMode;
      lineBytes <= widthBytes;
    end
  end

endmodule

/* verilog/modeLineEngine.sv */
/* Per-byte fetch and pixel codes for one mode line of mode 2 or mode 14.
   Mode 2 gives 64 codes per character, mode 14 gives 4 codes per data byte */
`include "antic_settings.svh"

module modeLineEngine (
  input  logic                    Fphi0,
  input  logic                    rst,
  input  logic                    MSRdataRdy,
  input  logic [`IR_WIDTH-1:0]    MSRdata,
  input  logic [`CHAR_BITS-1:0]   charData,
  input  logic                    charLoaded,
  lineIf.engine                   line,
  output logic                    loadMSRdata,
  output logic                    incrMSR,
  output logic                    loadChar,
  output anticPkg::anCode_t       pixelCode
);

  localparam int PixelWidth = $clog2(`CHAR_BITS);
  // Two bits per pixel in the map mode
  localparam int MapPixels = `IR_WIDTH / 2;

  typedef enum logic [1:0] {E_IDLE, E_DATA, E_CHAR, E_EMIT} engineState_t;

  engineState_t state;
  anticPkg::mode_t modeQ;
  logic [`BYTE_COUNT_WIDTH-1:0] bytesLeft;
  logic [PixelWidth-1:0] pixel;
  logic [PixelWidth-1:0] lastPixel;
  logic [`IR_WIDTH-1:0] dataByte;
  logic [`CHAR_BITS-1:0] bitmap;
  logic [1:0] colourSel;
  logic fetchQ;
  logic loadCharQ;
  logic doneQ;

  assign loadMSRdata = fetchQ;
  assign incrMSR = fetchQ;
  assign loadChar = loadCharQ;
  assign line.done = doneQ;

  assign lastPixel = (modeQ == anticPkg::CHAR2) ? PixelWidth'(`CHAR_BITS - 1)
                                                : PixelWidth'(MapPixels - 1);

  // Pixel k uses bits 2k and 2k+1, with bit 2k as the high bit
  assign colourSel = {dataByte[{pixel[1:0], 1'b0}], dataByte[{pixel[1:0], 1'b1}]};

  always_comb begin
    pixelCode = anticPkg::NONE;
    if (state == E_EMIT) begin
      if (modeQ == anticPkg::CHAR2) begin
        // Set bits are the text colour, clear bits its background
        pixelCode = bitmap[pixel] ? anticPkg::PF1 : anticPkg::PF2;
      end else begin
        case (colourSel)
          2'd0: pixelCode = anticPkg::BG;
          2'd1: pixelCode = anticPkg::PF0;
          2'd2: pixelCode = anticPkg::PF1;
          default: pixelCode = anticPkg::PF2;
        endcase
      end
    end
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      state <= E_IDLE;
      modeQ <= anticPkg::BLANK;
      bytesLeft <= '0;
      pixel <= '0;
      fetchQ <= 1'b0;
      loadCharQ <= 1'b0;
      doneQ <= 1'b0;
    end else begin
      fetchQ <= 1'b0;
      loadCharQ <= 1'b0;
      doneQ <= 1'b0;
      case (state)
        E_IDLE: begin
          if (line.start) begin
            modeQ <= line.mode;
            bytesLeft <= line.byteCount;
            // A zero-width playfield fetches nothing
            if (line.byteCount == '0) begin
              doneQ <= 1'b1;
            end else begin
              fetchQ <= 1'b1;
              state <= E_DATA;
            end
          end
        end
        E_DATA: begin
          if (MSRdataRdy) begin
            pixel <= '0;
            if (modeQ == anticPkg::CHAR2) begin
              loadCharQ <= 1'b1;
              state <= E_CHAR;
            end else begin
              state <= E_EMIT;
            end
          end
        end
        E_CHAR: begin
          if (charLoaded)
            state <= E_EMIT;
        end
        E_EMIT: begin
          if (pixel == lastPixel) begin
            bytesLeft <= bytesLeft - 1'b1;
            if (bytesLeft == `BYTE_COUNT_WIDTH'(1)) begin
              doneQ <= 1'b1;
              state <= E_IDLE;
            end else begin
              fetchQ <= 1'b1;
              state <= E_DATA;
            end
          end else begin
            pixel <= pixel + 1'b1;
          end
        end
        default: state <= E_IDLE;
      endcase
    end
  end

  // Data byte and bitmap are held for the whole run of codes they produce
  always_ff @(posedge Fphi0) begin
    if (state == E_DATA && MSRdataRdy)
      dataByte <= MSRdata;
    if (state == E_CHAR && charLoaded)
      bitmap <= charData;
  end

endmodule

/* verilog/operandFetch.sv */
/* Two-byte operand fetch for jump and LMS instructions.
   Each step follows the byteReady that answers the previous request by one cycle */

module operandFetch (
  input  logic       Fphi0,
  input  logic       rst,
  operandIf.fetcher  operand,
  input  logic       jvb,
  output logic       loadPtr,
  output logic       loadDLISTL,
  output logic       loadDLISTH,
  output logic       loadDLIST,
  output logic       writeDLIST,
  output logic       DLISTend,
  output logic       loadMSRL,
  output logic       loadMSRH
);

  typedef enum logic [1:0] {F_IDLE, F_LOW, F_HIGH, F_EXEC} fetchState_t;

  fetchState_t state;
  anticPkg::operandKind_t kindQ;
  logic isJump;
  logic byteRequestQ;
  logic doneQ;

  assign isJump = (kindQ == anticPkg::JUMP_OPERAND);
  assign operand.byteRequest = byteRequestQ;
  assign operand.done = doneQ;

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      state <= F_IDLE;
      kindQ <= anticPkg::JUMP_OPERAND;
      byteRequestQ <= 1'b0;
      doneQ <= 1'b0;
      loadPtr <= 1'b0;
      loadDLISTL <= 1'b0;
      loadDLISTH <= 1'b0;
      loadDLIST <= 1'b0;
      writeDLIST <= 1'b0;
      DLISTend <= 1'b0;
      loadMSRL <= 1'b0;
      loadMSRH <= 1'b0;
    end else begin
      // Everything except loadPtr is a single-cycle strobe
      byteRequestQ <= 1'b0;
      doneQ <= 1'b0;
      loadDLISTL <= 1'b0;
      loadDLISTH <= 1'b0;
      loadDLIST <= 1'b0;
      writeDLIST <= 1'b0;
      DLISTend <= 1'b0;
      loadMSRL <= 1'b0;
      loadMSRH <= 1'b0;
      case (state)
        F_IDLE: begin
          if (operand.start) begin
            kindQ <= operand.kind;
            byteRequestQ <= 1'b1;
            state <= F_LOW;
          end
        end
        F_LOW: begin
          if (operand.byteReady) begin
            // The high byte is requested as soon as the low byte is taken
            byteRequestQ <= 1'b1;
            loadDLISTL <= isJump;
            loadPtr <= isJump;
            loadMSRL <= !isJump;
            state <= F_HIGH;
          end
        end
        F_HIGH: begin
          if (operand.byteReady) begin
            if (isJump) begin
              loadDLISTH <= 1'b1;
              writeDLIST <= 1'b1;
              state <= F_EXEC;
            end else begin
              loadMSRH <= 1'b1;
              doneQ <= 1'b1;
              state <= F_IDLE;
            end
          end
        end
        F_EXEC: begin
          // Pointer now loads from the new address
          loadPtr <= 1'b0;
          loadDLIST <= 1'b1;
          DLISTend <= jvb;
          doneQ <= 1'b1;
          state <= F_IDLE;
        end
        default: state <= F_IDLE;
      endcase
    end
  end

endmodule
